//--- verilog.f
+incdir+source
source/driver_pkg.sv
source/lfsr8.sv
source/pattern_generator.sv
source/address_generator.sv
source/read_checker.sv
source/test_sequencer.sv
source/example_driver.sv
verif/tb_example_driver.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and search the log for the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 \
  --top-module tb_example_driver -f verilog.f -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^TEST PASSED$" sim.log; then
  exit 0
else
  exit 1
fi

//--- verif/tb_example_driver.sv
// tb_example_driver module: clock, reset, local port memory model, stimulus table, checks, watchdog
`timescale 1ns/10ps
`include "driver_macros.svh"

module tb_example_driver
  import driver_pkg::*;
();

  localparam int key_w = 1 + `BANK_WIDTH + `ROW_WIDTH + `COL_WIDTH;
  localparam int num_rows = 5;
  localparam int seq_cols = `MAX_COL / `COL_STEP + 1;
  localparam int seq_beats = seq_cols * (`MAX_ROW + 1) * (`MAX_BANK + 1) * (`MAX_CHIPSEL + 1);
  // both sequential passes plus a generous bound on the three walking passes
  localparam int beats_per_round = 2 * seq_beats + 3 * 32;

  // --------------------
  // stimulus table: ready percentage, read latency, fault lane (-1 none), fault beat
  int ready_pct[num_rows]  = '{100, 60, 40, 75, 50};
  int read_lat[num_rows]   = '{1, 3, 7, 2, 5};
  int fault_lane[num_rows] = '{-1, -1, 2, 5, -1};
  int fault_beat[num_rows] = '{0, 0, 10, 33, 0};

  logic       clk;
  logic       reset_n;
  logic       local_ready;
  data_word_t local_rdata;
  logic       local_rdata_valid;
  logic       local_write_req;
  logic       local_read_req;
  logic       local_burstbegin;
  logic       local_cs_addr;
  bank_t      local_bank_addr;
  row_t       local_row_addr;
  col_t       local_col_addr;
  byte_en_t   local_be;
  logic       local_size;
  data_word_t local_wdata;
  byte_en_t   pnf_per_byte;
  logic       pnf_persist;
  logic       test_complete;
  logic [7:0] test_status;

  // memory model, unwritten addresses read as zero
  data_word_t       mem [logic [key_w-1:0]];
  logic [key_w-1:0] rq_key[$];
  int               rq_due[$];

  integer seed;
  int     cycle;
  int     errors;
  int     checks;
  int     completes;
  int     seq_wr;
  int     seq_rd;
  int     seq_sweeps;
  int     dm_runs;
  int     dm_passes;
  int     dm_beats;
  int     beats_out;
  int     first_beat;
  int     fault_at;

  logic             prev_stalled;
  logic             prev_wr;
  logic             prev_rd;
  logic             prev_complete;
  logic             prev_seq;
  logic [key_w-1:0] prev_key;
  data_word_t       prev_wdata;
  byte_en_t         prev_be;

  example_driver i_dut (
    .clk              (clk),
    .reset_n          (reset_n),
    .local_ready      (local_ready),
    .local_rdata      (local_rdata),
    .local_rdata_valid(local_rdata_valid),
    .local_write_req  (local_write_req),
    .local_read_req   (local_read_req),
    .local_burstbegin (local_burstbegin),
    .local_cs_addr    (local_cs_addr),
    .local_bank_addr  (local_bank_addr),
    .local_row_addr   (local_row_addr),
    .local_col_addr   (local_col_addr),
    .local_be         (local_be),
    .local_size       (local_size),
    .local_wdata      (local_wdata),
    .pnf_per_byte     (pnf_per_byte),
    .pnf_persist      (pnf_persist),
    .test_complete    (test_complete),
    .test_status      (test_status)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      $display("mismatch %s: got 0x%0h, expected 0x%0h at %0t", name, actual, expected, $time);
    end
  endtask

  // address of beat idx in the column, row, bank, chip-select order
  function automatic logic [key_w-1:0] seq_key(input int idx);
    int nrow;
    int nbank;
    nrow  = `MAX_ROW + 1;
    nbank = `MAX_BANK + 1;
    return {1'(idx / (seq_cols * nrow * nbank)), bank_t'((idx / (seq_cols * nrow)) % nbank),
            row_t'((idx / seq_cols) % nrow), col_t'((idx % seq_cols) * `COL_STEP)};
  endfunction

  task automatic store_bytes(input logic [key_w-1:0] key, input data_word_t data,
                             input byte_en_t be);
    data_word_t word;
    word = mem.exists(key) ? mem[key] : '0;
    for (int lane = 0; lane < `BYTE_LANES; lane++)
    begin
      if (be[lane])
        word[8*lane +: 8] = data[8*lane +: 8];
    end
    mem[key] = word;
  endtask

  task automatic reset_dut();
    reset_n           = 1'b0;
    local_ready       = 1'b0;
    local_rdata_valid = 1'b0;
    local_rdata       = '0;
    mem.delete();
    rq_key.delete();
    rq_due.delete();
    cycle         = 0;
    completes     = 0;
    seq_wr        = 0;
    seq_rd        = 0;
    seq_sweeps    = 0;
    dm_runs       = 0;
    dm_passes     = 0;
    dm_beats      = 0;
    beats_out     = 0;
    first_beat    = -1;
    fault_at      = -1;
    prev_stalled  = 1'b0;
    prev_wr       = 1'b0;
    prev_rd       = 1'b0;
    prev_complete = 1'b0;
    prev_seq      = 1'b0;
    repeat (8) @(negedge clk);
    check_value("local_write_req", 64'(local_write_req), 64'd0);
    check_value("local_read_req", 64'(local_read_req), 64'd0);
    check_value("local_burstbegin", 64'(local_burstbegin), 64'd0);
    check_value("test_complete", 64'(test_complete), 64'd0);
    check_value("local_be", 64'(local_be), 64'hff);
    reset_n = 1'b1;
  endtask

  // one falling edge: check outputs, drive ready, update the model, return read data
  task automatic service_cycle(input int row);
    logic [key_w-1:0] key;
    logic [key_w-1:0] rkey;
    logic             accept_wr;
    logic             accept_rd;
    data_word_t       word;
    int               r;
    int               lane;
    key  = {local_cs_addr, local_bank_addr, local_row_addr, local_col_addr};
    lane = fault_lane[row];
    check_value("req_overlap", 64'(local_write_req & local_read_req), 64'd0);
    // single-beat bursts, so every request opens a burst
    check_value("local_burstbegin", 64'(local_burstbegin),
                64'(local_write_req | local_read_req));
    check_value("local_size", 64'(local_size), 64'd1);
    check_value("test_status_spare", 64'(test_status & 8'h7a), 64'd0);
    check_value("test_status[7]", 64'(test_status[7]), 64'(test_complete));
    if (prev_complete)
      check_value("test_complete", 64'(test_complete), 64'd0);
    if (test_complete && !prev_complete)
      completes++;
    // a stalled request must hold everything
    if (prev_stalled)
    begin
      check_value("local_write_req", 64'(local_write_req), 64'(prev_wr));
      check_value("local_read_req", 64'(local_read_req), 64'(prev_rd));
      check_value("local_addr", 64'(key), 64'(prev_key));
      // write data and enables travel with the write only
      if (prev_wr)
      begin
        check_value("local_wdata", local_wdata, prev_wdata);
        check_value("local_be", 64'(local_be), 64'(prev_be));
      end
    end
    if (prev_seq && !test_status[0])
    begin
      check_value("seq_write_beats", 64'(seq_wr), 64'(seq_beats));
      check_value("seq_read_beats", 64'(seq_rd), 64'(seq_beats));
      seq_sweeps++;
    end
    if (!test_status[0])
    begin
      seq_wr = 0;
      seq_rd = 0;
    end
    if (!test_status[2])
      dm_runs = 0;
    else if (local_write_req && !prev_wr)
    begin
      dm_runs++;
      dm_beats = 0;
      if (dm_runs == 2)
        dm_passes++;
    end
    // pass/not-fail follows the read beats by four cycles
    if (first_beat >= 0 && cycle >= first_beat + 4)
      check_value("pnf_persist", 64'(pnf_persist),
                  (fault_at >= 0 && cycle >= fault_at + 4) ? 64'd0 : 64'd1);
    else
      check_value("pnf_persist", 64'(pnf_persist), 64'd0);
    if (lane < 0)
      check_value("pnf_per_byte", 64'(pnf_per_byte), 64'hff);
    else if (fault_at >= 0 && cycle == fault_at + 3)
      check_value("pnf_per_byte_fault_lane", 64'(pnf_per_byte[lane]), 64'd0);

    r           = $random(seed);
    local_ready = ($unsigned(r) % 100) < ready_pct[row];
    accept_wr   = local_write_req && local_ready;
    accept_rd   = local_read_req && local_ready;
    if (accept_wr)
    begin
      if (test_status[0])
      begin
        check_value("write_addr", 64'(key), 64'(seq_key(seq_wr)));
        seq_wr++;
      end
      if (test_status[2] && dm_runs == 1)
      begin
        check_value("local_wdata", local_wdata, 64'd0);
        check_value("local_be", 64'(local_be), 64'hff);
      end
      if (test_status[2] && dm_runs == 2)
      begin
        check_value("local_be", 64'(local_be), 64'(8'h01 << (dm_beats % 8)));
        dm_beats++;
      end
      store_bytes(key, local_wdata, local_be);
    end
    if (accept_rd)
    begin
      if (test_status[0])
      begin
        check_value("read_addr", 64'(key), 64'(seq_key(seq_rd)));
        seq_rd++;
      end
      if (test_status[2])
        check_value("local_be_onehot", 64'($onehot(local_be)), 64'd1);
      rq_key.push_back(key);
      rq_due.push_back(cycle + read_lat[row]);
    end
    prev_stalled  = (local_write_req || local_read_req) && !local_ready;
    prev_wr       = local_write_req;
    prev_rd       = local_read_req;
    prev_key      = key;
    prev_wdata    = local_wdata;
    prev_be       = local_be;
    prev_complete = test_complete;
    prev_seq      = test_status[0];

    // in-order read return
    local_rdata_valid = 1'b0;
    if (rq_due.size() > 0 && rq_due[0] <= cycle)
    begin
      rkey = rq_key.pop_front();
      void'(rq_due.pop_front());
      word = mem.exists(rkey) ? mem[rkey] : '0;
      if (lane >= 0 && beats_out == fault_beat[row])
      begin
        word[8*lane +: 8] = ~word[8*lane +: 8];
        fault_at = cycle;
      end
      if (beats_out == 0)
        first_beat = cycle;
      beats_out++;
      local_rdata       = word;
      local_rdata_valid = 1'b1;
    end
    cycle++;
  endtask

  initial
  begin
    int row_errors;
    reset_n           = 1'b0;
    local_ready       = 1'b0;
    local_rdata       = '0;
    local_rdata_valid = 1'b0;
    seed              = 32'h7b16_dab4;
    errors            = 0;
    checks            = 0;
    for (int row = 0; row < num_rows; row++)
    begin
      row_errors = errors;
      reset_dut();
      // two full rounds of both tests
      while (completes < 2)
      begin
        @(negedge clk);
        service_cycle(row);
      end
      // each round runs one sequential sweep and one masked write pass
      check_value("seq_sweeps", 64'(seq_sweeps), 64'd2);
      check_value("dm_write_passes", 64'(dm_passes), 64'd2);
      $display("row %0d: ready %0d%%, latency %0d, fault lane %0d, %0d errors", row,
               ready_pct[row], read_lat[row], fault_lane[row], errors - row_errors);
    end
    $display("rows %0d, checks %0d, errors %0d", num_rows, checks, errors);
    if (errors == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

  // --------------------
  // watchdog
  initial
  begin
    int max_lat;
    longint limit_cycles;
    max_lat = 0;
    for (int row = 0; row < num_rows; row++)
    begin
      if (read_lat[row] > max_lat)
        max_lat = read_lat[row];
    end
    limit_cycles = longint'(num_rows) * 2 * beats_per_round * (max_lat + 4) + 1000;
    #(limit_cycles * 100);
    $display("timeout: the run did not finish within %0d clock cycles", limit_cycles);
    $display("TEST FAILED");
    $finish;
  end

endmodule

//--- source/example_driver.sv
// example_driver module: top level joining sequencer, address, pattern and checker blocks
`timescale 1ns/10ps

module example_driver
  import driver_pkg::*;
(
  input  logic       clk,
  input  logic       reset_n,
  input  logic       local_ready,
  input  data_word_t local_rdata,
  input  logic       local_rdata_valid,
  output logic       local_write_req,
  output logic       local_read_req,
  output logic       local_burstbegin,
  output logic       local_cs_addr,
  output bank_t      local_bank_addr,
  output row_t       local_row_addr,
  output col_t       local_col_addr,
  output byte_en_t   local_be,
  output logic       local_size,
  output data_word_t local_wdata,
  output byte_en_t   pnf_per_byte,
  output logic       pnf_persist,
  output logic       test_complete,
  output logic [7:0] test_status
);

  test_mode_t test_mode;
  logic       addr_advance;
  logic       write_accept;
  logic       reset_address;
  logic       clear_data;
  logic       capture_seed;
  logic       reload;
  logic       be_reset;
  logic       reached_max_address;
  data_word_t expected;

  // every access is a single beat
  assign local_size = 1'b1;

  // one bit per active test, bit 7 marks the end of a round
  assign test_status = {test_complete, 4'b0000, (test_mode == mode_dm_pin), 1'b0,
                        (test_mode == mode_seq_addr)};

  test_sequencer i_test_sequencer (
    .clk                (clk),
    .reset_n            (reset_n),
    .local_ready        (local_ready),
    .local_rdata_valid  (local_rdata_valid),
    .reached_max_address(reached_max_address),
    .write_req          (local_write_req),
    .read_req           (local_read_req),
    .burst_begin        (local_burstbegin),
    .addr_advance       (addr_advance),
    .write_accept       (write_accept),
    .test_mode          (test_mode),
    .reset_address      (reset_address),
    .clear_data         (clear_data),
    .capture_seed       (capture_seed),
    .reload             (reload),
    .be_reset           (be_reset),
    .test_complete      (test_complete)
  );

  address_generator i_address_generator (
    .clk                (clk),
    .reset_n            (reset_n),
    .test_mode          (test_mode),
    .addr_advance       (addr_advance),
    .reset_address      (reset_address),
    .cs_addr            (local_cs_addr),
    .bank_addr          (local_bank_addr),
    .row_addr           (local_row_addr),
    .col_addr           (local_col_addr),
    .reached_max_address(reached_max_address)
  );

  pattern_generator i_pattern_generator (
    .clk              (clk),
    .reset_n          (reset_n),
    .test_mode        (test_mode),
    .write_accept     (write_accept),
    .local_rdata_valid(local_rdata_valid),
    .clear_data       (clear_data),
    .capture_seed     (capture_seed),
    .reload           (reload),
    .be_reset         (be_reset),
    .wdata            (local_wdata),
    .expected         (expected),
    .be               (local_be)
  );

  read_checker i_read_checker (
    .clk              (clk),
    .reset_n          (reset_n),
    .local_rdata      (local_rdata),
    .local_rdata_valid(local_rdata_valid),
    .expected         (expected),
    .be               (local_be),
    .pnf_per_byte     (pnf_per_byte),
    .pnf_persist      (pnf_persist)
  );

endmodule

//--- source/test_sequencer.sv
// test_sequencer module: test FSM, request strobes and outstanding read counter
`timescale 1ns/10ps
`include "driver_macros.svh"

module test_sequencer
  import driver_pkg::*;
(
  input  logic       clk,
  input  logic       reset_n,
  input  logic       local_ready,
  input  logic       local_rdata_valid,
  input  logic       reached_max_address,
  output logic       write_req,
  output logic       read_req,
  output logic       burst_begin,
  output logic       addr_advance,
  output logic       write_accept,
  output test_mode_t test_mode,
  output logic       reset_address,
  output logic       clear_data,
  output logic       capture_seed,
  output logic       reload,
  output logic       be_reset,
  output logic       test_complete
);

  localparam int cw = `COUNT_WIDTH;

  test_state_t   state;
  logic          read_accept;
  logic [cw-1:0] reads_remaining;

  assign write_accept = write_req & local_ready;
  assign read_accept  = read_req & local_ready;
  assign addr_advance = write_accept | read_accept;

  // --------------------
  // outstanding read counter
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      reads_remaining <= '0;
    else
      reads_remaining <= reads_remaining + cw'(read_accept) - cw'(local_rdata_valid);
  end

  // --------------------
  // test FSM
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state         <= st_idle;
      test_mode     <= mode_none;
      write_req     <= 1'b0;
      read_req      <= 1'b0;
      burst_begin   <= 1'b0;
      reset_address <= 1'b0;
      clear_data    <= 1'b0;
      capture_seed  <= 1'b0;
      reload        <= 1'b0;
      be_reset      <= 1'b0;
      test_complete <= 1'b0;
    end
    else
    begin
      case (state)
        st_idle:
        begin
          test_complete <= 1'b0;
          reset_address <= 1'b1;
          test_mode     <= mode_seq_addr;
          state         <= st_start;
        end
        st_start:
        begin
          reset_address <= 1'b0;
          // the data-mask test begins with a pass of zeros
          clear_data    <= (test_mode == mode_dm_pin);
          capture_seed  <= 1'b1;
          write_req     <= 1'b1;
          burst_begin   <= 1'b1;
          state         <= st_write;
        end
        st_write:
        begin
          capture_seed <= 1'b0;
          if (write_accept && reached_max_address)
          begin
            write_req     <= 1'b0;
            burst_begin   <= 1'b0;
            reset_address <= 1'b1;
            state         <= st_write_drain;
          end
        end
        st_write_drain:
        begin
          // write data leaves with each accepted request, nothing is left to wait for
          reset_address <= 1'b0;
          reload        <= 1'b1;
          be_reset      <= (test_mode == mode_dm_pin);
          if (clear_data)
          begin
            clear_data <= 1'b0;
            state      <= st_reload;
          end
          else
          begin
            read_req    <= 1'b1;
            burst_begin <= 1'b1;
            state       <= st_read;
          end
        end
        st_reload:
        begin
          reload      <= 1'b0;
          be_reset    <= 1'b0;
          write_req   <= 1'b1;
          burst_begin <= 1'b1;
          state       <= st_write;
        end
        st_read:
        begin
          reload   <= 1'b0;
          be_reset <= 1'b0;
          if (read_accept && reached_max_address)
          begin
            read_req      <= 1'b0;
            burst_begin   <= 1'b0;
            reset_address <= 1'b1;
            state         <= st_read_drain;
          end
        end
        st_read_drain:
        begin
          reset_address <= 1'b0;
          // wait for the last read beat before moving on
          if (reads_remaining == '0)
          begin
            if (test_mode == mode_seq_addr)
            begin
              test_mode <= mode_dm_pin;
              state     <= st_start;
            end
            else
            begin
              test_mode     <= mode_none;
              test_complete <= 1'b1;
              state         <= st_complete;
            end
          end
        end
        st_complete:
        begin
          test_complete <= 1'b0;
          state         <= st_idle;
        end
        default:
          state <= st_idle;
      endcase
    end
  end

  a_req_exclusive: assert property (@(posedge clk) disable iff (!reset_n)
    !(write_req && read_req));

endmodule

//--- source/read_checker.sv
// read_checker module: masked per-lane compare and pass/not-fail pipeline
`timescale 1ns/10ps
`include "driver_macros.svh"

module read_checker
  import driver_pkg::*;
(
  input  logic       clk,
  input  logic       reset_n,
  input  data_word_t local_rdata,
  input  logic       local_rdata_valid,
  input  data_word_t expected,
  input  byte_en_t   be,
  output byte_en_t   pnf_per_byte,
  output logic       pnf_persist
);

  byte_en_t compare;
  byte_en_t compare_s1;
  byte_en_t compare_s2;
  logic     valid_s1;
  logic     checked;
  logic     checked_d;
  logic     pass_s3;

  // disabled lanes always pass
  always_comb
  begin
    for (int lane = 0; lane < `BYTE_LANES; lane++)
    begin
      compare[lane] = ~be[lane] | (local_rdata[8*lane +: 8] == expected[8*lane +: 8]);
    end
  end

  // --------------------
  // stage 1 registers the raw compare, stage 2 keeps it for valid beats only,
  // stage 3 drives the pins
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      compare_s1   <= '1;
      compare_s2   <= '1;
      pnf_per_byte <= '1;
      valid_s1     <= 1'b0;
      checked      <= 1'b0;
      checked_d    <= 1'b0;
      pass_s3      <= 1'b0;
      pnf_persist  <= 1'b0;
    end
    else
    begin
      compare_s1 <= compare;
      valid_s1   <= local_rdata_valid;
      if (valid_s1)
        compare_s2 <= compare_s1;
      // set once the first beat has reached stage 2
      checked      <= checked | valid_s1;
      checked_d    <= checked;
      pnf_per_byte <= compare_s2;
      // first checked beat decides alone, afterwards any failure sticks
      pass_s3     <= checked & (&compare_s2) & (pass_s3 | ~checked_d);
      pnf_persist <= pass_s3;
    end
  end

endmodule

//--- source/address_generator.sv
// address_generator module: sequential and walking-one address sweeps, end detection
`timescale 1ns/10ps
`include "driver_macros.svh"

module address_generator
  import driver_pkg::*;
(
  input  logic       clk,
  input  logic       reset_n,
  input  test_mode_t test_mode,
  input  logic       addr_advance,
  input  logic       reset_address,
  output logic       cs_addr,
  output bank_t      bank_addr,
  output row_t       row_addr,
  output col_t       col_addr,
  output logic       reached_max_address
);

  localparam col_t  col_last  = col_t'(`MAX_COL);
  localparam row_t  row_last  = row_t'(`MAX_ROW);
  localparam bank_t bank_last = bank_t'(`MAX_BANK);
  localparam logic  cs_last   = 1'(`MAX_CHIPSEL);
  localparam col_t  col_step  = col_t'(`COL_STEP);
  // walking-one turning points on the row
  localparam row_t  row_top   = {1'b1, {(`ROW_WIDTH-1){1'b0}}};
  localparam row_t  row_low   = {1'b0, {(`ROW_WIDTH-1){1'b1}}};

  logic seq_last;
  logic walk_last;

  assign seq_last = (col_addr == col_last) && (row_addr == row_last) &&
                    (bank_addr == bank_last) && (cs_addr == cs_last);
  assign walk_last = (row_addr == '1);
  assign reached_max_address = ((test_mode == mode_seq_addr) && seq_last) ||
                               ((test_mode == mode_dm_pin) && walk_last);

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      cs_addr   <= 1'b0;
      bank_addr <= '0;
      row_addr  <= '0;
      col_addr  <= '0;
    end
    else if (reset_address)
    begin
      cs_addr   <= 1'b0;
      bank_addr <= '0;
      row_addr  <= '0;
      col_addr  <= '0;
    end
    else if (addr_advance && test_mode == mode_dm_pin)
    begin
      if (row_addr == '0)
      begin
        col_addr <= col_t'(4);
        row_addr <= row_t'(1);
      end
      else if (row_addr == row_top)
      begin
        // one reached the top, continue as a walking zero
        col_addr <= {{(`COL_WIDTH-3){1'b1}}, 3'b000};
        row_addr <= {{(`ROW_WIDTH-1){1'b1}}, 1'b0};
      end
      else if (row_addr == row_low)
      begin
        col_addr <= {{(`COL_WIDTH-2){1'b1}}, 2'b00};
        row_addr <= '1;
      end
      else
      begin
        col_addr <= {col_addr[`COL_WIDTH-2:2], col_addr[`COL_WIDTH-1], col_addr[1:0]};
        row_addr <= {row_addr[`ROW_WIDTH-2:0], row_addr[`ROW_WIDTH-1]};
      end
      bank_addr <= (bank_addr == bank_last) ? '0 : bank_addr + 1'b1;
      cs_addr   <= (cs_addr == cs_last) ? 1'b0 : cs_addr + 1'b1;
    end
    else if (addr_advance && test_mode == mode_seq_addr)
    begin
      // column, then row, bank and chip select carry in turn
      if (col_addr >= col_last)
      begin
        col_addr <= '0;
        if (row_addr == row_last)
        begin
          row_addr <= '0;
          if (bank_addr == bank_last)
          begin
            bank_addr <= '0;
            cs_addr   <= (cs_addr == cs_last) ? 1'b0 : cs_addr + 1'b1;
          end
          else
            bank_addr <= bank_addr + 1'b1;
        end
        else
          row_addr <= row_addr + 1'b1;
      end
      else
        col_addr <= col_addr + col_step;
    end
  end

  a_seq_col_range: assert property (@(posedge clk) disable iff (!reset_n)
    (test_mode == mode_seq_addr) |-> (col_addr <= col_last));

endmodule

//--- source/pattern_generator.sv
// pattern_generator module: lfsr data lanes, replay store and byte-enable rotation
`timescale 1ns/10ps
`include "driver_macros.svh"

module pattern_generator
  import driver_pkg::*;
(
  input  logic       clk,
  input  logic       reset_n,
  input  test_mode_t test_mode,
  input  logic       write_accept,
  input  logic       local_rdata_valid,
  input  logic       clear_data,
  input  logic       capture_seed,
  input  logic       reload,
  input  logic       be_reset,
  output data_word_t wdata,
  output data_word_t expected,
  output byte_en_t   be
);

  localparam int lanes = `BYTE_LANES;

  logic       advance;
  logic       lfsr_run;
  logic       dm_mode;
  data_word_t lfsr_data;
  data_word_t reload_data;

  // step on every written data beat and every returned read beat
  assign advance  = (write_accept & ~clear_data) | local_rdata_valid;
  assign lfsr_run = (test_mode != mode_none);
  assign dm_mode  = (test_mode == mode_dm_pin);

  for (genvar lane = 0; lane < lanes; lane++)
  begin : g_lane
    lfsr8 #(
      .seed(8'(`LFSR_SEED_BASE + lane * `LFSR_SEED_STEP))
    ) i_lfsr (
      .clk    (clk),
      .reset_n(reset_n),
      .enable (lfsr_run),
      .pause  (~advance),
      .load   (reload),
      .ldata  (reload_data[8*lane +: 8]),
      .data   (lfsr_data[8*lane +: 8])
    );
  end

  // state at the first write, so the read pass replays the same stream
  always_ff @(posedge clk)
  begin
    if (capture_seed)
      reload_data <= lfsr_data;
  end

  assign wdata    = clear_data ? '0 : lfsr_data;
  assign expected = lfsr_data;

  // --------------------
  // byte enables
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      be <= '1;
    else if (be_reset)
      be <= byte_en_t'(1);
    else if (dm_mode && advance)
      be <= {be[lanes-2:0], be[lanes-1]};
    // zero pass and other tests write every lane
    else if (!dm_mode || clear_data)
      be <= '1;
  end

  a_be_shape: assert property (@(posedge clk) disable iff (!reset_n)
    (be == '1) || $onehot(be));

endmodule

//--- source/lfsr8.sv
// lfsr8 module: one 8-bit maximal-length pseudo-random byte lane
`timescale 1ns/10ps

module lfsr8 #(
  parameter logic [7:0] seed = 8'd1
) (
  input  logic       clk,
  input  logic       reset_n,
  input  logic       enable,
  input  logic       pause,
  input  logic       load,
  input  logic [7:0] ldata,
  output logic [7:0] data
);

  // galois feedback for x^8 + x^4 + x^3 + x^2 + 1
  localparam logic [7:0] taps = 8'h1d;

  logic feedback;

  assign feedback = data[7];

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      data <= seed;
    // held at the seed while disabled
    else if (!enable)
      data <= seed;
    else if (load)
      data <= ldata;
    else if (!pause)
      data <= {data[6:0], 1'b0} ^ ({8{feedback}} & taps);
  end

endmodule

//--- source/driver_pkg.sv
// data word, byte enable, address field, test mode and sequencer state types
`include "driver_macros.svh"

package driver_pkg;

  typedef logic [`DATA_WIDTH-1:0] data_word_t;
  typedef logic [`BYTE_LANES-1:0] byte_en_t;
  typedef logic [`ROW_WIDTH-1:0] row_t;
  typedef logic [`COL_WIDTH-1:0] col_t;
  typedef logic [`BANK_WIDTH-1:0] bank_t;

  // which test currently owns the local port
  typedef enum logic [1:0] {mode_none, mode_seq_addr, mode_dm_pin} test_mode_t;

  typedef enum logic [2:0] {
    st_idle, st_start, st_write, st_write_drain, st_reload, st_read, st_read_drain, st_complete
  } test_state_t;

endpackage

//--- source/driver_macros.svh
// local port widths, sequential sweep limits, lfsr seeds and counter width
`ifndef DRIVER_MACROS_SVH
`define DRIVER_MACROS_SVH

// --------------------
// local port widths
`define DATA_WIDTH 64
`define BYTE_LANES 8
`define ROW_WIDTH 13
`define COL_WIDTH 10
`define BANK_WIDTH 2

// --------------------
// last address of the sequential sweep
`define MAX_ROW 3
`define MAX_COL 16
`define MAX_BANK 3
`define MAX_CHIPSEL 0
// column increment for one local beat
`define COL_STEP 4

// lane n is seeded with base + n * step
`define LFSR_SEED_BASE 1
`define LFSR_SEED_STEP 10

// outstanding write/read counters
`define COUNT_WIDTH 8

`endif
